/* Makefile */
TOP := ooo_alu_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f ooo_alu_core.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f ooo_alu_core.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

/* hw/alu_station.sv */
`include "ooo_consts.svh"

module alu_station (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               accept,
    input  ooo_pkg::issue_op_t op,
    input  ooo_pkg::ptag_t     dest_tag,
    input  ooo_pkg::rob_idx_t  rob_slot,
    input  ooo_pkg::ptag_t     src1_tag,
    input  ooo_pkg::ptag_t     src2_tag,
    input  ooo_pkg::xdata_t    src1_data,
    input  ooo_pkg::xdata_t    src2_data,
    input  logic               src1_ready,
    input  logic               src2_ready,
    output logic               full,
    output ooo_pkg::cdb_t      cdb
);

    localparam int N     = `OOO_RS_DEPTH;
    localparam int IDX_W = $clog2(N);

    typedef struct packed {
        ooo_pkg::ptag_t  tag;
        logic            rdy;
        ooo_pkg::xdata_t data;
    } rs_src_t;

    typedef struct packed {
        ooo_pkg::alu_op_t  op;
        ooo_pkg::ptag_t    dest;
        ooo_pkg::rob_idx_t slot;
        rs_src_t           a;
        rs_src_t           b;
    } rs_entry_t;

    rs_entry_t        ents [N];
    logic [N-1:0]     used;
    logic [N-1:0]     ready;
    logic [IDX_W-1:0] alloc_idx;
    logic [IDX_W-1:0] pick_idx;
    logic             pick_valid;
    rs_src_t          in_a;
    rs_src_t          in_b;

    // broadcast match, tag 0 never wakes anything
    function automatic logic cdb_hit(input ooo_pkg::cdb_t b, input ooo_pkg::ptag_t tag);
        cdb_hit = b.valid && (b.tag != '0) && (b.tag == tag);
    endfunction

    function automatic ooo_pkg::xdata_t alu_eval(
        input ooo_pkg::alu_op_t f,
        input ooo_pkg::xdata_t  a,
        input ooo_pkg::xdata_t  b
    );
        case (f)
            ooo_pkg::ALU_ADD: alu_eval = a + b;
            ooo_pkg::ALU_SUB: alu_eval = a - b;
            ooo_pkg::ALU_AND: alu_eval = a & b;
            ooo_pkg::ALU_OR:  alu_eval = a | b;
            ooo_pkg::ALU_XOR: alu_eval = a ^ b;
            ooo_pkg::ALU_SLL: alu_eval = a << b[4:0];
            ooo_pkg::ALU_SRL: alu_eval = a >> b[4:0];
            default:          alu_eval = {{(`OOO_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
        endcase
    endfunction

    // operands at issue, with same-cycle broadcast bypass
    always_comb begin
        in_a.tag  = src1_tag;
        in_a.rdy  = src1_ready;
        in_a.data = src1_data;
        if (cdb_hit(cdb, src1_tag)) begin
            in_a.rdy  = 1'b1;
            in_a.data = cdb.value;
        end
        in_b.tag  = src2_tag;
        in_b.rdy  = src2_ready;
        in_b.data = src2_data;
        if (op.use_imm) begin
            in_b.tag  = '0;
            in_b.rdy  = 1'b1;
            in_b.data = op.imm;
        end else if (cdb_hit(cdb, src2_tag)) begin
            in_b.rdy  = 1'b1;
            in_b.data = cdb.value;
        end
    end

    always_comb begin
        alloc_idx = '0;
        pick_idx  = '0;
        for (int i = N - 1; i >= 0; i--) begin
            ready[i] = used[i] && ents[i].a.rdy && ents[i].b.rdy;
            if (!used[i]) begin
                alloc_idx = IDX_W'(i);
            end
            if (ready[i]) begin
                pick_idx = IDX_W'(i);   // lowest ready wins
            end
        end
    end

    assign pick_valid = |ready;
    assign full       = &used;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            used <= '0;
            cdb  <= '0;
        end else begin
            if (pick_valid) begin
                used[pick_idx] <= 1'b0;
            end
            if (accept) begin
                used[alloc_idx] <= 1'b1;
            end
            cdb.valid   <= pick_valid;
            cdb.tag     <= ents[pick_idx].dest;
            cdb.rob_idx <= ents[pick_idx].slot;
            cdb.value   <= alu_eval(ents[pick_idx].op, ents[pick_idx].a.data,
                                    ents[pick_idx].b.data);
        end
    end

    // wakeup, then the new entry overrides its own slot
    always_ff @(posedge clk) begin
        for (int i = 0; i < N; i++) begin
            if (!ents[i].a.rdy && cdb_hit(cdb, ents[i].a.tag)) begin
                ents[i].a.rdy  <= 1'b1;
                ents[i].a.data <= cdb.value;
            end
            if (!ents[i].b.rdy && cdb_hit(cdb, ents[i].b.tag)) begin
                ents[i].b.rdy  <= 1'b1;
                ents[i].b.data <= cdb.value;
            end
        end
        if (accept) begin
            ents[alloc_idx].op   <= op.op;
            ents[alloc_idx].dest <= dest_tag;
            ents[alloc_idx].slot <= rob_slot;
            ents[alloc_idx].a    <= in_a;
            ents[alloc_idx].b    <= in_b;
        end
    end

endmodule

/* hw/arch_reg_file.sv */
`include "ooo_consts.svh"

module arch_reg_file (
    input  logic             clk,
    input  logic             rst_n,
    input  ooo_pkg::commit_t commit,
    input  ooo_pkg::areg_t   read_addr,
    output ooo_pkg::xdata_t  read_data
);

    ooo_pkg::xdata_t regs_q [`OOO_ARCH_REGS];

    assign read_data = regs_q[read_addr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `OOO_ARCH_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (commit.valid && (commit.rd != '0)) begin
            regs_q[commit.rd] <= commit.value;  // r0 stays zero
        end
    end

endmodule

/* hw/ooo_alu_core.sv */
module ooo_alu_core (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               issue_valid,
    input  ooo_pkg::issue_op_t issue_op,
    output logic               busy,
    output ooo_pkg::commit_t   commit,
    input  ooo_pkg::areg_t     read_addr,
    output ooo_pkg::xdata_t    read_data
);

    logic              accept;
    logic              free_empty;
    logic              rob_full;
    logic              rs_full;
    ooo_pkg::ptag_t    src1_tag;
    ooo_pkg::ptag_t    src2_tag;
    ooo_pkg::ptag_t    new_tag;
    ooo_pkg::ptag_t    old_tag;
    ooo_pkg::xdata_t   src1_data;
    ooo_pkg::xdata_t   src2_data;
    logic              src1_ready;
    logic              src2_ready;
    ooo_pkg::rob_idx_t rob_tail;
    ooo_pkg::cdb_t     cdb;
    ooo_pkg::commit_t  rob_commit;

    assign busy   = free_empty | rob_full | rs_full;
    assign accept = issue_valid & ~busy;  // strobes during busy are dropped

    // old_tag stays internal
    always_comb begin
        commit         = rob_commit;
        commit.old_tag = '0;
    end

    rename_table u_rename_table (
        .clk        (clk),
        .rst_n      (rst_n),
        .alloc      (accept),
        .alloc_rd   (issue_op.rd),
        .rs1        (issue_op.rs1),
        .rs2        (issue_op.rs2),
        .src1_tag   (src1_tag),
        .src2_tag   (src2_tag),
        .new_tag    (new_tag),
        .old_tag    (old_tag),
        .free_empty (free_empty),
        .commit     (rob_commit)
    );

    phys_reg_file u_phys_reg_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_tag1   (src1_tag),
        .rd_tag2   (src2_tag),
        .rd_data1  (src1_data),
        .rd_data2  (src2_data),
        .rd_ready1 (src1_ready),
        .rd_ready2 (src2_ready),
        .clear     (accept),
        .clear_tag (new_tag),
        .cdb       (cdb)
    );

    alu_station u_alu_station (
        .clk        (clk),
        .rst_n      (rst_n),
        .accept     (accept),
        .op         (issue_op),
        .dest_tag   (new_tag),
        .rob_slot   (rob_tail),
        .src1_tag   (src1_tag),
        .src2_tag   (src2_tag),
        .src1_data  (src1_data),
        .src2_data  (src2_data),
        .src1_ready (src1_ready),
        .src2_ready (src2_ready),
        .full       (rs_full),
        .cdb        (cdb)
    );

    reorder_buffer u_reorder_buffer (
        .clk     (clk),
        .rst_n   (rst_n),
        .alloc   (accept),
        .rd      (issue_op.rd),
        .new_tag (new_tag),
        .old_tag (old_tag),
        .tail    (rob_tail),
        .full    (rob_full),
        .cdb     (cdb),
        .commit  (rob_commit)
    );

    arch_reg_file u_arch_reg_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .commit    (rob_commit),
        .read_addr (read_addr),
        .read_data (read_data)
    );

endmodule

/* hw/ooo_consts.svh */
`ifndef OOO_CONSTS_SVH
`define OOO_CONSTS_SVH

// register counts
`define OOO_ARCH_REGS 32
`define OOO_PHYS_REGS 64

// physical tag width, log2 of OOO_PHYS_REGS
`define OOO_TAG_W 6

// reorder buffer
`define OOO_ROB_DEPTH 16
`define OOO_ROB_IDX_W 4

// alu reservation station entries
`define OOO_RS_DEPTH 4

// data word
`define OOO_XLEN 32

`endif

/* hw/ooo_pkg.sv */
`include "ooo_consts.svh"

package ooo_pkg;

    typedef logic [`OOO_XLEN-1:0]                xdata_t;
    typedef logic [$clog2(`OOO_ARCH_REGS)-1:0]   areg_t;
    typedef logic [`OOO_TAG_W-1:0]               ptag_t;
    typedef logic [`OOO_ROB_IDX_W-1:0]           rob_idx_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7
    } alu_op_t;

    // decoded operation from the issuer
    typedef struct packed {
        alu_op_t op;
        areg_t   rd;
        areg_t   rs1;
        areg_t   rs2;
        logic    use_imm;   // imm replaces rs2
        xdata_t  imm;
    } issue_op_t;

    typedef struct packed {
        logic     valid;
        ptag_t    tag;      // 0 when the op has no destination
        rob_idx_t rob_idx;
        xdata_t   value;
    } cdb_t;

    typedef struct packed {
        logic   valid;
        areg_t  rd;
        xdata_t value;
        ptag_t  old_tag;    // goes back to the free list
    } commit_t;

endpackage

/* hw/phys_reg_file.sv */
`include "ooo_consts.svh"

module phys_reg_file (
    input  logic            clk,
    input  logic            rst_n,
    input  ooo_pkg::ptag_t  rd_tag1,
    input  ooo_pkg::ptag_t  rd_tag2,
    output ooo_pkg::xdata_t rd_data1,
    output ooo_pkg::xdata_t rd_data2,
    output logic            rd_ready1,
    output logic            rd_ready2,
    input  logic            clear,
    input  ooo_pkg::ptag_t  clear_tag,
    input  ooo_pkg::cdb_t   cdb
);

    ooo_pkg::xdata_t           regs_q [`OOO_PHYS_REGS];
    logic [`OOO_PHYS_REGS-1:0] valid_q;

    assign rd_data1  = regs_q[rd_tag1];
    assign rd_data2  = regs_q[rd_tag2];
    assign rd_ready1 = valid_q[rd_tag1];
    assign rd_ready2 = valid_q[rd_tag2];

    // tag 0 belongs to r0 and stays zero and valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `OOO_PHYS_REGS; i++) begin
                regs_q[i] <= '0;
            end
            valid_q <= '1;
        end else begin
            if (clear && (clear_tag != '0)) begin
                valid_q[clear_tag] <= 1'b0;   // new destination, value pending
            end
            if (cdb.valid && (cdb.tag != '0)) begin
                regs_q[cdb.tag]  <= cdb.value;
                valid_q[cdb.tag] <= 1'b1;
            end
        end
    end

endmodule

/* hw/rename_table.sv */
`include "ooo_consts.svh"

module rename_table (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             alloc,
    input  ooo_pkg::areg_t   alloc_rd,
    input  ooo_pkg::areg_t   rs1,
    input  ooo_pkg::areg_t   rs2,
    output ooo_pkg::ptag_t   src1_tag,
    output ooo_pkg::ptag_t   src2_tag,
    output ooo_pkg::ptag_t   new_tag,
    output ooo_pkg::ptag_t   old_tag,
    output logic             free_empty,
    input  ooo_pkg::commit_t commit
);

    localparam int FREE_N = `OOO_PHYS_REGS - `OOO_ARCH_REGS;
    localparam int PTR_W  = $clog2(FREE_N);

    ooo_pkg::ptag_t   map_q [`OOO_ARCH_REGS];
    ooo_pkg::ptag_t   free_q [FREE_N];
    logic [PTR_W-1:0] free_head;
    logic [PTR_W-1:0] free_tail;
    logic [PTR_W:0]   free_cnt;
    logic             pop;
    logic             push;

    // r0 never gets a new tag
    assign pop  = alloc && (alloc_rd != '0);
    assign push = commit.valid && (commit.rd != '0);

    // lookups see the map before this cycle's rename
    assign src1_tag   = map_q[rs1];
    assign src2_tag   = map_q[rs2];
    assign old_tag    = map_q[alloc_rd];
    assign new_tag    = (alloc_rd != '0) ? free_q[free_head] : '0;  // tag 0 = no destination
    assign free_empty = (free_cnt == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `OOO_ARCH_REGS; i++) begin
                map_q[i] <= ooo_pkg::ptag_t'(i);
            end
            for (int i = 0; i < FREE_N; i++) begin
                free_q[i] <= ooo_pkg::ptag_t'(`OOO_ARCH_REGS + i);
            end
            free_head <= '0;
            free_tail <= '0;
            free_cnt  <= (PTR_W+1)'(FREE_N);
        end else begin
            if (pop) begin
                map_q[alloc_rd] <= free_q[free_head];
                free_head       <= free_head + 1'b1;
            end
            if (push) begin
                free_q[free_tail] <= commit.old_tag;
                free_tail         <= free_tail + 1'b1;
            end
            case ({push, pop})
                2'b10:   free_cnt <= free_cnt + 1'b1;
                2'b01:   free_cnt <= free_cnt - 1'b1;
                default: free_cnt <= free_cnt;
            endcase
        end
    end

endmodule

/* hw/reorder_buffer.sv */
`include "ooo_consts.svh"

module reorder_buffer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              alloc,
    input  ooo_pkg::areg_t    rd,
    input  ooo_pkg::ptag_t    new_tag,
    input  ooo_pkg::ptag_t    old_tag,
    output ooo_pkg::rob_idx_t tail,
    output logic              full,
    input  ooo_pkg::cdb_t     cdb,
    output ooo_pkg::commit_t  commit
);

    localparam int N     = `OOO_ROB_DEPTH;
    localparam int CNT_W = `OOO_ROB_IDX_W + 1;

    ooo_pkg::areg_t    rd_q [N];
    ooo_pkg::ptag_t    new_q [N];
    ooo_pkg::ptag_t    old_q [N];
    ooo_pkg::xdata_t   val_q [N];
    logic [N-1:0]      done_q;
    ooo_pkg::rob_idx_t head;
    logic [CNT_W-1:0]  cnt;
    logic              retire;
    logic              finish;

    assign retire = (cnt != '0) && done_q[head];
    assign full   = (cnt == CNT_W'(N));
    // slot and destination tag must both agree
    assign finish = cdb.valid && (new_q[cdb.rob_idx] == cdb.tag);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head   <= '0;
            tail   <= '0;
            cnt    <= '0;
            done_q <= '0;
            commit <= '0;
        end else begin
            if (alloc) begin
                done_q[tail] <= 1'b0;
                tail         <= tail + 1'b1;
            end
            if (finish) begin
                done_q[cdb.rob_idx] <= 1'b1;
            end
            commit.valid   <= retire;
            commit.rd      <= rd_q[head];
            commit.value   <= val_q[head];
            commit.old_tag <= old_q[head];
            if (retire) begin
                head <= head + 1'b1;
            end
            case ({alloc, retire})
                2'b10:   cnt <= cnt + 1'b1;
                2'b01:   cnt <= cnt - 1'b1;
                default: cnt <= cnt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            rd_q[tail]  <= rd;
            new_q[tail] <= new_tag;
            old_q[tail] <= old_tag;
        end
        if (finish) begin
            val_q[cdb.rob_idx] <= cdb.value;
        end
    end

endmodule

/* ooo_alu_core.f */
+incdir+hw
hw/ooo_pkg.sv
hw/rename_table.sv
hw/phys_reg_file.sv
hw/alu_station.sv
hw/reorder_buffer.sv
hw/arch_reg_file.sv
hw/ooo_alu_core.sv
verif/ooo_alu_core_tb.sv

/* verif/ooo_alu_core_tb.sv */
`include "ooo_consts.svh"

module ooo_alu_core_tb;

    localparam int NUM_OPS     = 2000;
    localparam int WATCHDOG    = NUM_OPS * 20 * 8;
    localparam int DRAIN_LIMIT = 200;

    logic               clk;
    logic               rst_n;
    logic               issue_valid;
    ooo_pkg::issue_op_t issue_op;
    logic               busy;
    ooo_pkg::commit_t   commit;
    ooo_pkg::areg_t     read_addr;
    ooo_pkg::xdata_t    read_data;

    logic [31:0]        lfsr_q;
    ooo_pkg::issue_op_t exp_q [$];                    // accepted, not yet committed
    ooo_pkg::xdata_t    model_regs [`OOO_ARCH_REGS];
    logic [7:0]         ops_seen = '0;
    int                 accept_cnt = 0;
    int                 drop_cnt = 0;
    int                 commit_cnt = 0;
    int                 zero_rd_cnt = 0;
    int                 value_errs = 0;
    int                 other_errs = 0;
    int                 scan_errs = 0;
    int                 check_errs = 0;

    ooo_alu_core dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .busy        (busy),
        .commit      (commit),
        .read_addr   (read_addr),
        .read_data   (read_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            r      = {r[30:0], lfsr_q[0]};
        end
        rand_bits = r;
    endfunction

    // mostly r0..r5 so that chains form
    function automatic ooo_pkg::areg_t pick_reg();
        logic [31:0] r;
        r = rand_bits(2);
        if (r != 0) begin
            r = rand_bits(3);
            if (r > 5) r = r - 6;
        end else begin
            r = rand_bits(5);
        end
        pick_reg = r[4:0];
    endfunction

    function automatic ooo_pkg::issue_op_t random_op();
        ooo_pkg::issue_op_t o;
        logic [31:0]        r;
        r         = rand_bits(3);
        o.op      = ooo_pkg::alu_op_t'(r[2:0]);
        o.rd      = pick_reg();
        o.rs1     = pick_reg();
        o.rs2     = pick_reg();
        r         = rand_bits(1);
        o.use_imm = r[0];
        r         = rand_bits(1);
        if (r[0]) begin
            o.imm = rand_bits(32);
        end else begin
            r     = rand_bits(8);   // small signed values for slt
            o.imm = {{24{r[7]}}, r[7:0]};
        end
        random_op = o;
    endfunction

    function automatic ooo_pkg::xdata_t ref_alu(input ooo_pkg::alu_op_t f,
                                                input ooo_pkg::xdata_t a,
                                                input ooo_pkg::xdata_t b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f)
            ooo_pkg::ALU_ADD: ref_alu = a + b;
            ooo_pkg::ALU_SUB: ref_alu = a - b;
            ooo_pkg::ALU_AND: ref_alu = a & b;
            ooo_pkg::ALU_OR:  ref_alu = a | b;
            ooo_pkg::ALU_XOR: ref_alu = a ^ b;
            ooo_pkg::ALU_SLL: ref_alu = a << sh;
            ooo_pkg::ALU_SRL: ref_alu = a >> sh;
            default:          ref_alu = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;  // slt
        endcase
    endfunction

    // commit check first, then note this cycle's acceptance
    always @(negedge clk) begin
        ooo_pkg::issue_op_t o;
        ooo_pkg::xdata_t    b;
        ooo_pkg::xdata_t    v;
        if (rst_n) begin
            if (commit.valid) begin
                commit_cnt++;
                assert (exp_q.size() > 0) else begin
                    other_errs++;
                    $display("commit at %0t with no accepted operation pending", $time);
                end
                if (exp_q.size() > 0) begin
                    o = exp_q.pop_front();
                    b = o.use_imm ? o.imm : model_regs[o.rs2];
                    v = ref_alu(o.op, model_regs[o.rs1], b);
                    assert (commit.rd == o.rd) else begin
                        value_errs++;
                        $display("Error %0t: commit.rd = %0d, expected %0d",
                                 $time, commit.rd, o.rd);
                    end
                    assert (commit.value == v) else begin
                        value_errs++;
                        $display("Error %0t: commit.value = %08h, expected %08h",
                                 $time, commit.value, v);
                    end
                    if (o.rd != 0) model_regs[o.rd] = v;
                    else zero_rd_cnt++;
                    ops_seen[o.op] = 1'b1;
                end
            end
            if (issue_valid) begin
                if (!busy) begin
                    exp_q.push_back(issue_op);
                    accept_cnt++;
                end else begin
                    drop_cnt++;   // lost by design
                end
            end
        end
    end

    task automatic scan_regs();
        for (int r = 0; r < `OOO_ARCH_REGS; r++) begin
            @(posedge clk);
            read_addr <= ooo_pkg::areg_t'(r);
            @(negedge clk);
            assert (read_data == model_regs[r]) else begin
                scan_errs++;
                $display("Error %0t: read_data (r%0d) = %08h, expected %08h",
                         $time, r, read_data, model_regs[r]);
            end
        end
    endtask

    // sparse traffic with bursts that run into busy
    task automatic run_random(input int n_ops);
        int sent;
        int burst;
        sent  = 0;
        burst = 0;
        while (sent < n_ops) begin
            @(posedge clk);
            if (burst == 0 && rand_bits(4) == 0) burst = 8 + int'(rand_bits(4));
            if (burst > 0 || rand_bits(2) == 0) begin
                issue_valid <= 1'b1;
                issue_op    <= random_op();
                sent++;
                if (burst > 0) burst--;
            end else begin
                issue_valid <= 1'b0;
            end
        end
        @(posedge clk);
        issue_valid <= 1'b0;
    endtask

    task automatic drain_pipeline();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        assert (exp_q.size() == 0) else begin
            check_errs++;
            $display("%0d accepted operations did not commit within %0d cycles",
                     exp_q.size(), DRAIN_LIMIT);
        end
        repeat (40) begin
            @(negedge clk);
            assert (!busy && !commit.valid) else begin
                check_errs++;
                $display("busy or a commit seen at %0t after the pipeline drained", $time);
            end
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        issue_valid = 1'b0;
        issue_op    = '0;
        read_addr   = '0;
        lfsr_q      = 32'h9232b0cd;
        for (int i = 0; i < `OOO_ARCH_REGS; i++) model_regs[i] = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (!busy && !commit.valid) else begin
            check_errs++;
            $display("busy or commit.valid high right after reset");
        end
        scan_regs();
        run_random(NUM_OPS);
        drain_pipeline();
        scan_regs();
        assert (accept_cnt == commit_cnt) else begin
            check_errs++;
            $display("%0d operations accepted but %0d committed", accept_cnt, commit_cnt);
        end
        assert (drop_cnt > 0) else begin
            check_errs++;
            $display("bursts never raised busy so no strobe was dropped");
        end
        assert (zero_rd_cnt > 0 && ops_seen == 8'hff) else begin
            check_errs++;
            $display("not every alu operation or an rd 0 operation was committed");
        end
        $display("accepted %0d, dropped %0d, value errors %0d, read errors %0d, other errors %0d",
                 accept_cnt, drop_cnt, value_errs, scan_errs, other_errs + check_errs);
        if (value_errs + scan_errs + other_errs + check_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG);
        $display("watchdog expired after %0d time units, the run did not finish", WATCHDOG);
        $display(">>> FAIL");
        $finish;
    end

endmodule
